// File: trapUnit.f
verilog/trapPkg.sv
verilog/pcReadIf.sv
verilog/trapInfoIf.sv
verilog/pcFile.sv
verilog/trapCsr.sv
verilog/trapHandler.sv
verilog/trapUnit.sv
verif/trapUnitTb.sv

// File: verif/trapUnitTb.sv
`timescale 1ns/1ps

module trapUnitTb;
    import trapPkg::*;

    typedef struct packed {
        BranchProv branch;
        BPUpdate bp;
        logic trapValid;
        logic [31:0] trapPC;
        logic [3:0] cause;
        logic delegate;
        logic isInterrupt;
        logic halt;
        logic fence;
    } Expect_t;

    typedef struct packed {
        Priv_t priv;
        logic [29:0] mtvec;
        logic [29:0] stvec;
        logic [15:0] medeleg;
        logic [15:0] mideleg;
        logic [30:0] mepc;
        logic [30:0] sepc;
    } CsrModel_t;

    logic clk;
    logic rst;
    logic pcWrite;
    FetchID_t pcWriteId;
    PCFileEntry pcWriteEntry;
    Trap_UOp trapInstr;
    logic csrWrite;
    CsrAddr_t csrAddr;
    logic [31:0] csrData;
    logic irq;
    logic memBusy;
    logic allowBreak;
    BranchProv branch;
    BPUpdate bpUpdate;
    logic trapValid;
    logic [31:0] trapPC;
    logic [3:0] trapCause;
    logic trapDelegate;
    logic trapIsInterrupt;
    logic fence;
    logic clearICache;
    logic disableIFetch;
    logic halt;

    integer seed;
    int cycleCount = 0;
    logic checking;
    logic irqPending;
    CsrModel_t csrModel;
    PCFileEntry pcModel [16];
    Expect_t expQ [$];
    int dueQ [$];

    trapUnit uut (
        .clk(clk),
        .rst(rst),
        .pcWrite(pcWrite),
        .pcWriteId(pcWriteId),
        .pcWriteEntry(pcWriteEntry),
        .trapInstr(trapInstr),
        .csrWrite(csrWrite),
        .csrAddr(csrAddr),
        .csrData(csrData),
        .irq(irq),
        .memBusy(memBusy),
        .allowBreak(allowBreak),
        .branch(branch),
        .bpUpdate(bpUpdate),
        .trapValid(trapValid),
        .trapPC(trapPC),
        .trapCause(trapCause),
        .trapDelegate(trapDelegate),
        .trapIsInterrupt(trapIsInterrupt),
        .fence(fence),
        .clearICache(clearICache),
        .disableIFetch(disableIFetch),
        .halt(halt)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic stopWithFail(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // expected response of one committing micro-op.
    function automatic Expect_t refModel(input Trap_UOp op, input PCFileEntry e,
            input CsrModel_t csr, input logic irqPend, input logic brkAllowed);
        Expect_t r;
        logic [30:0] hw;
        BHist_t hist;
        logic brk;
        logic redirect;
        logic exc;
        logic [3:0] cause;
        logic deleg;
        r = '0;
        if (!op.valid) begin
            return r;
        end
        // halfword address of the first parcel.
        hw = {e.pc[31:4], op.fetchOffs};
        if (!op.compressed) begin
            hw = hw - 31'd1;
        end
        hist = e.hist;
        if (e.bpi.predicted && e.bpi.isJump == 3'd0 && op.fetchOffs > e.branchPos) begin
            hist = {e.hist[HIST_W-2:0], e.bpi.taken};
        end
        brk = op.flags == FLAGS_TRAP && op.name == TRAP_BREAK && brkAllowed;
        redirect = brk || op.flags == FLAGS_FENCE || op.flags == FLAGS_ORDERING;
        exc = 1'b1;
        case (op.flags)
            FLAGS_ILLEGAL_INSTR: cause = 4'd2;
            FLAGS_TRAP: cause = op.name[3:0];
            FLAGS_LD_MA: cause = 4'd4;
            FLAGS_LD_AF: cause = 4'd5;
            FLAGS_ST_MA: cause = 4'd6;
            FLAGS_ST_AF: cause = 4'd7;
            FLAGS_LD_PF: cause = 4'd13;
            FLAGS_ST_PF: cause = 4'd15;
            default: begin
                exc = 1'b0;
                cause = 4'd0;
            end
        endcase
        if (op.flags == FLAGS_TRAP && op.name == TRAP_ECALL_M) begin
            if (csr.priv == PRIV_USER) begin
                cause = TRAP_ECALL_U[3:0];
            end else if (csr.priv == PRIV_SUPERVISOR) begin
                cause = TRAP_ECALL_S[3:0];
            end
        end
        if (redirect) begin
            r.branch.dstPC = {hw + (op.compressed ? 31'd1 : 31'd2), 1'b0};
            r.halt = brk;
            r.fence = op.flags == FLAGS_FENCE;
        end else if (exc || irqPend) begin
            if (irqPend) begin
                cause = 4'd0;
            end
            deleg = csr.priv != PRIV_MACHINE
                && (irqPend ? csr.mideleg[cause] : csr.medeleg[cause]);
            r.branch.dstPC = {deleg ? csr.stvec : csr.mtvec, 2'b00};
            r.trapValid = 1'b1;
            r.trapPC = {hw, 1'b0};
            r.cause = cause;
            r.delegate = deleg;
            r.isInterrupt = irqPend;
        end else if (op.flags == FLAGS_XRET) begin
            r.branch.dstPC = {csr.priv == PRIV_SUPERVISOR ? csr.sepc : csr.mepc, 1'b0};
        end else begin
            r.bp.valid = 1'b1;
            r.bp.pc = e.pc;
            r.bp.compressed = op.compressed;
            r.bp.history = e.hist;
            r.bp.bpi = e.bpi;
            r.bp.branchTaken = op.flags == FLAGS_PRED_TAKEN;
        end
        if (!r.bp.valid) begin
            r.branch.taken = 1'b1;
            r.branch.flush = 1'b1;
            r.branch.sqN = op.sqN;
            r.branch.fetchID = op.fetchID;
            r.branch.history = hist;
        end
        return r;
    endfunction

    task automatic compareBranch(input BranchProv got, input BranchProv want);
        if (got !== want) begin
            stopWithFail($sformatf("error at %0t: branch got %h expected %h",
                $time, got, want));
        end
    endtask

    task automatic compareBpUpdate(input BPUpdate got, input BPUpdate want);
        if (got !== want) begin
            stopWithFail($sformatf("error at %0t: bpUpdate got %h expected %h",
                $time, got, want));
        end
    endtask

    task automatic compareTrap(input logic gotValid, input logic [31:0] gotPC,
            input logic [3:0] gotCause, input logic gotDeleg, input logic gotIntr,
            input Expect_t want);
        if (gotValid !== want.trapValid) begin
            stopWithFail($sformatf("error at %0t: trapValid got %b expected %b",
                $time, gotValid, want.trapValid));
        end
        // the other trap fields only mean something with valid high.
        if (want.trapValid && {gotPC, gotCause, gotDeleg, gotIntr}
                !== {want.trapPC, want.cause, want.delegate, want.isInterrupt}) begin
            stopWithFail($sformatf(
                "error at %0t: trap pc/cause/deleg/intr got %h/%0d/%b/%b expected %h/%0d/%b/%b",
                $time, gotPC, gotCause, gotDeleg, gotIntr,
                want.trapPC, want.cause, want.delegate, want.isInterrupt));
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic want);
        if (got !== want) begin
            stopWithFail($sformatf("error at %0t: %s got %b expected %b",
                $time, name, got, want));
        end
    endtask

    // outputs are stable at the falling edge; idle cycles expect all pulses low.
    always @(negedge clk) begin : checkOutputs
        Expect_t want;
        if (checking) begin
            want = '0;
            if (dueQ.size() > 0 && dueQ[0] == cycleCount) begin
                want = expQ.pop_front();
                void'(dueQ.pop_front());
            end
            compareBranch(branch, want.branch);
            compareBpUpdate(bpUpdate, want.bp);
            compareTrap(trapValid, trapPC, trapCause, trapDelegate, trapIsInterrupt, want);
            compareBit("halt", halt, want.halt);
            compareBit("fence", fence, want.fence);
        end
    end

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic makeOp(input Flags_t f, input logic [4:0] nm, output Trap_UOp op);
        logic [31:0] rnd;
        rnd = $random(seed);
        op.valid = 1'b1;
        op.flags = f;
        op.name = nm;
        op.fetchOffs = rnd[2:0];
        op.compressed = rnd[3];
        op.sqN = rnd[9:4];
        op.fetchID = rnd[13:10];
    endtask

    task automatic sendOp(input Trap_UOp op);
        Expect_t want;
        want = refModel(op, pcModel[op.fetchID], csrModel, irqPending, allowBreak);
        trapInstr = op;
        expQ.push_back(want);
        dueQ.push_back(cycleCount + 1);
        if (want.trapValid) begin
            if (want.isInterrupt) begin
                irqPending = 1'b0;
            end
            if (want.delegate) begin
                csrModel.sepc = want.trapPC[31:1];
                csrModel.priv = PRIV_SUPERVISOR;
            end else begin
                csrModel.mepc = want.trapPC[31:1];
                csrModel.priv = PRIV_MACHINE;
            end
        end
        idle(1);
        trapInstr = '0;
        // the CSR block settles one cycle after a trap.
        if (want.trapValid) begin
            idle(1);
        end
    endtask

    task automatic writeCsr(input CsrAddr_t a, input logic [31:0] d);
        csrWrite = 1'b1;
        csrAddr = a;
        csrData = d;
        case (a)
            MTVEC: csrModel.mtvec = d[31:2];
            STVEC: csrModel.stvec = d[31:2];
            MEDELEG: csrModel.medeleg = d[15:0];
            MIDELEG: csrModel.mideleg = d[15:0];
            PRIV: csrModel.priv = Priv_t'(d[1:0]);
            default: begin
            end
        endcase
        idle(1);
        csrWrite = 1'b0;
    endtask

    task automatic writePcEntry(input FetchID_t id);
        PCFileEntry e;
        logic [31:0] rnd;
        e.pc = $random(seed);
        rnd = $random(seed);
        e.hist = rnd[7:0];
        e.bpi = rnd[12:8];
        e.branchPos = rnd[15:13];
        pcModel[id] = e;
        pcWrite = 1'b1;
        pcWriteId = id;
        pcWriteEntry = e;
        idle(1);
        pcWrite = 1'b0;
    endtask

    task automatic pulseIrq();
        irq = 1'b1;
        idle(1);
        irq = 1'b0;
        irqPending = 1'b1;
    endtask

    task automatic holdBusy(input int n);
        repeat (n) begin
            @(negedge clk);
            if (disableIFetch !== 1'b1) begin
                stopWithFail("disableIFetch was low while memory was still busy");
            end
        end
        @(posedge clk);
        #10;
    endtask

    // release memBusy and wait for fetch to come back.
    task automatic drainMemory(input int wantClears);
        int clears;
        int i;
        logic done;
        clears = 0;
        done = 1'b0;
        memBusy = 1'b0;
        for (i = 0; i < 20 && !done; i++) begin
            @(negedge clk);
            if (clearICache === 1'b1) begin
                clears++;
            end
            if (disableIFetch === 1'b0) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            stopWithFail("timeout waiting for disableIFetch to fall");
        end
        if (clears != wantClears) begin
            stopWithFail($sformatf("error at %0t: clearICache pulses got %0d expected %0d",
                $time, clears, wantClears));
        end
        @(posedge clk);
        #10;
    endtask

    initial begin : watchdog
        int i;
        for (i = 0; i < 3000; i++) begin
            @(posedge clk);
        end
        stopWithFail("simulation did not finish within 3000 cycles");
    end

    initial begin : stimulus
        Trap_UOp op;
        logic [31:0] rnd;
        int k;
        seed = 32'h3e2e8357;
        clk = 1'b0;
        rst = 1'b1;
        pcWrite = 1'b0;
        pcWriteId = '0;
        pcWriteEntry = '0;
        trapInstr = '0;
        csrWrite = 1'b0;
        csrAddr = MTVEC;
        csrData = '0;
        irq = 1'b0;
        memBusy = 1'b0;
        allowBreak = 1'b0;
        checking = 1'b0;
        irqPending = 1'b0;
        csrModel = '0;
        csrModel.priv = PRIV_MACHINE;

        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        checking = 1'b1;

        for (k = 0; k < 16; k++) begin
            writePcEntry(k[3:0]);
        end
        writeCsr(MTVEC, $random(seed));
        writeCsr(STVEC, $random(seed));

        // predictor updates, back to back.
        for (k = 0; k < 40; k++) begin
            rnd = $random(seed);
            makeOp(rnd[0] ? FLAGS_PRED_TAKEN : FLAGS_NONE, rnd[5:1], op);
            sendOp(op);
        end

        // every exception flag from machine mode.
        for (k = 4; k <= 11; k++) begin
            makeOp(Flags_t'(k[3:0]), TRAP_ECALL_M, op);
            sendOp(op);
        end
        makeOp(FLAGS_TRAP, TRAP_BREAK, op);
        sendOp(op);
        writeCsr(PRIV, 32'd1);
        makeOp(FLAGS_TRAP, TRAP_ECALL_M, op);
        sendOp(op);

        // delegated load page fault from user mode, then return.
        writeCsr(MEDELEG, 32'h0000_2000);
        writeCsr(PRIV, 32'd0);
        makeOp(FLAGS_LD_PF, 5'd0, op);
        sendOp(op);
        makeOp(FLAGS_XRET, 5'd0, op);
        sendOp(op);

        memBusy = 1'b1;
        makeOp(FLAGS_FENCE, 5'd0, op);
        sendOp(op);
        holdBusy(3);
        drainMemory(1);

        // irq must skip the ordering op and land on the next normal one.
        pulseIrq();
        memBusy = 1'b1;
        makeOp(FLAGS_ORDERING, 5'd0, op);
        sendOp(op);
        holdBusy(2);
        drainMemory(0);
        makeOp(FLAGS_NONE, 5'd0, op);
        sendOp(op);
        makeOp(FLAGS_NONE, 5'd0, op);
        sendOp(op);

        allowBreak = 1'b1;
        makeOp(FLAGS_TRAP, TRAP_BREAK, op);
        op.compressed = 1'b1;
        sendOp(op);
        makeOp(FLAGS_TRAP, TRAP_BREAK, op);
        op.compressed = 1'b0;
        sendOp(op);
        allowBreak = 1'b0;

        idle(3);
        if (expQ.size() != 0) begin
            stopWithFail("some expected responses never came due");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: verilog/trapUnit.sv
`timescale 1ns/1ps

module trapUnit (
    input logic clk,
    input logic rst,
    input logic pcWrite,
    input trapPkg::FetchID_t pcWriteId,
    input trapPkg::PCFileEntry pcWriteEntry,
    input trapPkg::Trap_UOp trapInstr,
    input logic csrWrite,
    input trapPkg::CsrAddr_t csrAddr,
    input logic [31:0] csrData,
    input logic irq,
    input logic memBusy,
    input logic allowBreak,
    output trapPkg::BranchProv branch,
    output trapPkg::BPUpdate bpUpdate,
    output logic trapValid,
    output logic [31:0] trapPC,
    output logic [3:0] trapCause,
    output logic trapDelegate,
    output logic trapIsInterrupt,
    output logic fence,
    output logic clearICache,
    output logic disableIFetch,
    output logic halt
);
    import trapPkg::*;

    TrapControlState ctrl;

    pcReadIf pcRd ();
    trapInfoIf trapInfo ();

    pcFile pcFileInst (
        .clk(clk),
        .rst(rst),
        .wrEn(pcWrite),
        .wrId(pcWriteId),
        .wrData(pcWriteEntry),
        .rd(pcRd.target)
    );

    trapCsr trapCsrInst (
        .clk(clk),
        .rst(rst),
        .csrWrite(csrWrite),
        .csrAddr(csrAddr),
        .csrData(csrData),
        .trap(trapInfo.sink),
        .ctrl(ctrl)
    );

    trapHandler trapHandlerInst (
        .clk(clk),
        .rst(rst),
        .trapInstr(trapInstr),
        .pcRd(pcRd.initiator),
        .ctrl(ctrl),
        .trap(trapInfo.source),
        .branch(branch),
        .bpUpdate(bpUpdate),
        .irq(irq),
        .memBusy(memBusy),
        .allowBreak(allowBreak),
        .fence(fence),
        .clearICache(clearICache),
        .disableIFetch(disableIFetch),
        .halt(halt)
    );

    // trap report also leaves the unit for the rest of the core.
    assign trapValid = trapInfo.valid;
    assign trapPC = trapInfo.trapPC;
    assign trapCause = trapInfo.cause;
    assign trapDelegate = trapInfo.delegate;
    assign trapIsInterrupt = trapInfo.isInterrupt;

endmodule

// File: verilog/trapHandler.sv
`timescale 1ns/1ps

module trapHandler (
    input logic clk,
    input logic rst,
    input trapPkg::Trap_UOp trapInstr,
    pcReadIf.initiator pcRd,
    input trapPkg::TrapControlState ctrl,
    trapInfoIf.source trap,
    output trapPkg::BranchProv branch,
    output trapPkg::BPUpdate bpUpdate,
    input logic irq,
    input logic memBusy,
    input logic allowBreak,
    output logic fence,
    output logic clearICache,
    output logic disableIFetch,
    output logic halt
);
    import trapPkg::*;

    logic memoryWait;
    logic instrFence;
    logic externalIrq;

    PCFileEntry entry;
    logic [30:0] basePC;
    BHist_t baseHist;

    logic isBreak;
    logic redirectNext;
    logic isException;
    logic isXret;
    logic isInterrupt;
    logic takeTrap;
    logic [3:0] excCause;
    logic [3:0] trapCause;
    logic delegate;

    assign disableIFetch = memoryWait;

    assign pcRd.addr = trapInstr.fetchID;
    assign entry = pcRd.data;

    // fetchOffs names the last halfword, so a full-size instruction starts one earlier.
    assign basePC = {entry.pc[31:4], trapInstr.fetchOffs}
        - (trapInstr.compressed ? 31'd0 : 31'd1);

    // a predicted branch before us in the block has already shifted the history.
    always_comb begin
        if (entry.bpi.predicted && entry.bpi.isJump == 3'd0
            && trapInstr.fetchOffs > entry.branchPos) begin
            baseHist = {entry.hist[HIST_W-2:0], entry.bpi.taken};
        end else begin
            baseHist = entry.hist;
        end
    end

    always_comb begin
        isBreak = trapInstr.flags == FLAGS_TRAP && allowBreak && trapInstr.name == TRAP_BREAK;
        redirectNext = isBreak || trapInstr.flags == FLAGS_FENCE
            || trapInstr.flags == FLAGS_ORDERING;
        isException = trapInstr.flags >= FLAGS_ILLEGAL_INSTR && trapInstr.flags <= FLAGS_ST_PF;
        isXret = trapInstr.flags == FLAGS_XRET;
        isInterrupt = externalIrq && !redirectNext;
        takeTrap = !redirectNext && (isException || externalIrq);
    end

    always_comb begin
        case (trapInstr.flags)
            FLAGS_TRAP: excCause = trapInstr.name[3:0];
            FLAGS_ILLEGAL_INSTR: excCause = 4'd2;
            FLAGS_LD_MA: excCause = 4'd4;
            FLAGS_LD_AF: excCause = 4'd5;
            FLAGS_ST_MA: excCause = 4'd6;
            FLAGS_ST_AF: excCause = 4'd7;
            FLAGS_LD_PF: excCause = 4'd13;
            FLAGS_ST_PF: excCause = 4'd15;
            default: excCause = 4'd0;
        endcase

        // ecall is decoded as the machine variant.
        if (excCause == TRAP_ECALL_M[3:0]) begin
            case (ctrl.priv)
                PRIV_SUPERVISOR: excCause = TRAP_ECALL_S[3:0];
                PRIV_USER: excCause = TRAP_ECALL_U[3:0];
                default: begin
                end
            endcase
        end

        trapCause = isInterrupt ? 4'd0 : excCause;
        delegate = (ctrl.priv != PRIV_MACHINE)
            && (isInterrupt ? ctrl.mideleg[trapCause] : ctrl.medeleg[trapCause]);
    end

    always_ff @(posedge clk) begin
        halt <= 1'b0;
        fence <= 1'b0;
        clearICache <= 1'b0;
        branch <= '0;
        bpUpdate <= '0;
        trap.valid <= 1'b0;

        if (rst) begin
            memoryWait <= 1'b0;
            instrFence <= 1'b0;
            externalIrq <= 1'b0;
        end else begin
            externalIrq <= externalIrq | irq;

            // wait for stores to drain; a fence then flushes the icache once.
            if (memoryWait && !memBusy) begin
                if (instrFence) begin
                    instrFence <= 1'b0;
                    clearICache <= 1'b1;
                end else begin
                    memoryWait <= 1'b0;
                end
            end

            if (trapInstr.valid) begin
                if (redirectNext) begin
                    if (isBreak) begin
                        halt <= 1'b1;
                    end else begin
                        memoryWait <= 1'b1;
                    end
                    if (trapInstr.flags == FLAGS_FENCE) begin
                        instrFence <= 1'b1;
                        fence <= 1'b1;
                    end
                    branch.taken <= 1'b1;
                    branch.dstPC <= {basePC + (trapInstr.compressed ? 31'd1 : 31'd2), 1'b0};
                    branch.sqN <= trapInstr.sqN;
                    branch.flush <= 1'b1;
                    branch.fetchID <= trapInstr.fetchID;
                    branch.history <= baseHist;
                end else if (takeTrap || isXret) begin
                    branch.taken <= 1'b1;
                    branch.sqN <= trapInstr.sqN;
                    branch.flush <= 1'b1;
                    branch.fetchID <= trapInstr.fetchID;
                    branch.history <= baseHist;
                    if (takeTrap) begin
                        branch.dstPC <= {delegate ? ctrl.stvec : ctrl.mtvec, 2'b00};
                        trap.valid <= 1'b1;
                        trap.trapPC <= {basePC, 1'b0};
                        trap.cause <= trapCause;
                        trap.delegate <= delegate;
                        trap.isInterrupt <= isInterrupt;
                        if (isInterrupt) begin
                            externalIrq <= 1'b0;
                        end
                    end else begin
                        branch.dstPC <= {ctrl.retvec, 1'b0};
                    end
                end else begin
                    bpUpdate.valid <= 1'b1;
                    bpUpdate.pc <= entry.pc;
                    bpUpdate.compressed <= trapInstr.compressed;
                    bpUpdate.history <= entry.hist;
                    bpUpdate.bpi <= entry.bpi;
                    bpUpdate.branchTaken <= trapInstr.flags == FLAGS_PRED_TAKEN;
                end
            end
        end
    end

    // each committing micro-op either redirects or trains the predictor, never both.
    branchXorUpdate: assert property (
        @(posedge clk) disable iff (rst)
        trapInstr.valid |=> (branch.taken != bpUpdate.valid)
    );

endmodule

// File: verilog/trapCsr.sv
`timescale 1ns/1ps

module trapCsr (
    input logic clk,
    input logic rst,
    input logic csrWrite,
    input trapPkg::CsrAddr_t csrAddr,
    input logic [31:0] csrData,
    trapInfoIf.sink trap,
    output trapPkg::TrapControlState ctrl
);
    import trapPkg::*;

    Priv_t priv;
    logic [29:0] mtvec;
    logic [29:0] stvec;
    logic [15:0] medeleg;
    logic [15:0] mideleg;
    logic [30:0] mepc;
    logic [30:0] sepc;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= PRIV_MACHINE;
            mtvec <= '0;
            stvec <= '0;
            medeleg <= '0;
            mideleg <= '0;
            mepc <= '0;
            sepc <= '0;
        end else begin
            if (csrWrite) begin
                case (csrAddr)
                    MTVEC: mtvec <= csrData[31:2];
                    STVEC: stvec <= csrData[31:2];
                    MEDELEG: medeleg <= csrData[15:0];
                    MIDELEG: mideleg <= csrData[15:0];
                    PRIV: priv <= Priv_t'(csrData[1:0]);
                    default: begin
                    end
                endcase
            end

            // a trap overrides a CSR write to priv in the same cycle.
            if (trap.valid) begin
                if (trap.delegate) begin
                    sepc <= trap.trapPC[31:1];
                    priv <= PRIV_SUPERVISOR;
                end else begin
                    mepc <= trap.trapPC[31:1];
                    priv <= PRIV_MACHINE;
                end
            end
        end
    end

    always_comb begin
        ctrl.priv = priv;
        ctrl.mtvec = mtvec;
        ctrl.stvec = stvec;
        ctrl.medeleg = medeleg;
        ctrl.mideleg = mideleg;
        ctrl.retvec = (priv == PRIV_SUPERVISOR) ? sepc : mepc;
    end

    // the handler decided delegation on the level it saw a cycle earlier.
    noDelegFromMachine: assert property (
        @(posedge clk) disable iff (rst)
        (trap.valid && trap.delegate) |-> ($past(priv) != PRIV_MACHINE)
    );

endmodule

// File: verilog/pcFile.sv
`timescale 1ns/1ps

module pcFile (
    input logic clk,
    input logic rst,
    input logic wrEn,
    input trapPkg::FetchID_t wrId,
    input trapPkg::PCFileEntry wrData,
    pcReadIf.target rd
);
    import trapPkg::*;

    localparam int NUM_ENTRIES = 1 << FETCH_ID_W;

    PCFileEntry entries [NUM_ENTRIES];

    // one entry per fetch block, filled by the fetch stage.
    always_ff @(posedge clk) begin
        if (wrEn) begin
            entries[wrId] <= wrData;
        end
    end

    // the trap handler reads in the same cycle it sees the micro-op.
    always_comb begin
        rd.data = entries[rd.addr];
    end

    // an unknown index would corrupt an arbitrary block.
    wrIdKnown: assert property (
        @(posedge clk) disable iff (rst)
        wrEn |-> !$isunknown(wrId)
    );

endmodule

// File: verilog/trapInfoIf.sv
`timescale 1ns/1ps

interface trapInfoIf;
    logic valid;
    logic [31:0] trapPC;
    logic [3:0] cause;
    logic delegate;
    logic isInterrupt;

    // valid is a single-cycle pulse.
    modport source (
        output valid, trapPC, cause, delegate, isInterrupt
    );

    modport sink (
        input valid, trapPC, cause, delegate, isInterrupt
    );
endinterface

// File: verilog/pcReadIf.sv
`timescale 1ns/1ps

interface pcReadIf;
    import trapPkg::*;

    FetchID_t addr;
    PCFileEntry data;

    modport initiator (
        output addr,
        input data
    );

    modport target (
        input addr,
        output data
    );
endinterface

// File: verilog/trapPkg.sv
package trapPkg;

localparam int FETCH_ID_W = 4;
localparam int HIST_W = 8;
localparam int SQN_W = 6;

typedef logic [FETCH_ID_W-1:0] FetchID_t;
typedef logic [HIST_W-1:0] BHist_t;
typedef logic [SQN_W-1:0] SqN_t;

// exceptions span FLAGS_ILLEGAL_INSTR up to FLAGS_ST_PF.
typedef enum logic [3:0] {
    FLAGS_NONE,
    FLAGS_PRED_TAKEN,
    FLAGS_FENCE,
    FLAGS_ORDERING,
    FLAGS_ILLEGAL_INSTR,
    FLAGS_TRAP,
    FLAGS_LD_MA,
    FLAGS_LD_AF,
    FLAGS_LD_PF,
    FLAGS_ST_MA,
    FLAGS_ST_AF,
    FLAGS_ST_PF,
    FLAGS_XRET
} Flags_t;

typedef enum logic [1:0] {
    PRIV_USER = 2'd0,
    PRIV_SUPERVISOR = 2'd1,
    PRIV_MACHINE = 2'd3
} Priv_t;

localparam logic [4:0] TRAP_BREAK = 5'd3;
localparam logic [4:0] TRAP_ECALL_U = 5'd8;
localparam logic [4:0] TRAP_ECALL_S = 5'd9;
localparam logic [4:0] TRAP_ECALL_M = 5'd11;

typedef struct packed {
    logic predicted;
    logic taken;
    logic [2:0] isJump;
} BranchPredInfo;

typedef struct packed {
    logic [31:0] pc;
    BHist_t hist;
    BranchPredInfo bpi;
    logic [2:0] branchPos;
} PCFileEntry;

typedef struct packed {
    logic valid;
    Flags_t flags;
    logic [4:0] name;
    logic [2:0] fetchOffs;
    logic compressed;
    SqN_t sqN;
    FetchID_t fetchID;
} Trap_UOp;

typedef struct packed {
    logic taken;
    logic [31:0] dstPC;
    SqN_t sqN;
    logic flush;
    FetchID_t fetchID;
    BHist_t history;
} BranchProv;

typedef struct packed {
    logic valid;
    logic [31:0] pc;
    logic compressed;
    BHist_t history;
    BranchPredInfo bpi;
    logic branchTaken;
} BPUpdate;

typedef enum logic [2:0] {
    MTVEC,
    STVEC,
    MEDELEG,
    MIDELEG,
    PRIV
} CsrAddr_t;

// vectors are word addresses, retvec a halfword address.
typedef struct packed {
    Priv_t priv;
    logic [29:0] mtvec;
    logic [29:0] stvec;
    logic [15:0] medeleg;
    logic [15:0] mideleg;
    logic [30:0] retvec;
} TrapControlState;

endpackage
